// ==== project.f ====
+incdir+source
source/ooo_pkg.sv
source/insn_fifo.sv
source/dispatch.sv
source/rob.sv
source/rsv_station.sv
source/ooo_core_top.sv
testbench/ooo_core_props.sv
testbench/ooo_core_tb.sv

// ==== testbench/ooo_core_tb.sv ====
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int RAND_COUNT     = 200;
    localparam int FORCED_COUNT   = 12;
    localparam int BP_COUNT       = 20;
    localparam int NUM_INSNS      = RAND_COUNT + FORCED_COUNT + BP_COUNT;
    localparam int TIMEOUT_CYCLES = 40 * NUM_INSNS + 200;
    localparam logic [`XLEN-1:0] BASE_PC = 32'h0000_1000;
    localparam logic [6:0] OPCODE_UNKNOWN = 7'b0001011;  // custom-0, not decoded

    // A result waiting in the execution-unit model
    typedef struct packed {
        logic [`TAG_WIDTH-1:0] tag;
        logic [`XLEN-1:0]      data;
        logic [31:0]           due;
    } pending_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        insn_push;
    insn_entry_t insn_in;
    cdb_t        cdb_in;
    logic        insn_full;
    issue_t      issue_out;
    commit_t     commit_out;

    logic [`XLEN-1:0] model_regs [32];
    commit_t          exp_q [$];
    pending_t         pend_q [$];
    logic [`XLEN-1:0] issue_exp [NUM_INSNS];  // Word the station should issue, by push order
    logic [NUM_INSNS-1:0] issue_wait;
    logic [`XLEN-1:0] pc;
    logic             cdb_hold;
    logic             full_seen;
    int unsigned      cycle_count = 0;
    int unsigned      push_count = 0;
    int unsigned      commit_count = 0;
    int unsigned      hold_commits = 0;
    int unsigned      forced_issues = 0;
    int unsigned      mismatch_errors = 0;
    int unsigned      other_errors = 0;

    always #5 clk = ~clk;

    ooo_core_top i_ooo_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .insn_push  (insn_push),
        .insn_in    (insn_in),
        .cdb_in     (cdb_in),
        .insn_full  (insn_full),
        .issue_out  (issue_out),
        .commit_out (commit_out)
    );

    // ********************************************************
    // Execution rule and reference model
    // ********************************************************
    function automatic logic [`XLEN-1:0] exec_result(input logic [6:0] opcode,
            input logic [`XLEN-1:0] iaddr, input logic [`XLEN-1:0] a,
            input logic [`XLEN-1:0] b);
        if (opcode == OPCODE_OP || opcode == OPCODE_BRANCH) return a + b + iaddr;
        return a + iaddr;
    endfunction

    function automatic logic [`XLEN-1:0] ref_result(input logic [`XLEN-1:0] insn,
            input logic [`XLEN-1:0] iaddr);
        logic [6:0]       opcode;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        opcode = insn[6:0];
        a = '0;
        b = '0;
        case (opcode)
            OPCODE_OP, OPCODE_BRANCH, OPCODE_STORE: begin
                a = model_regs[insn[19:15]];
                b = model_regs[insn[24:20]];
            end
            OPCODE_OPIMM, OPCODE_JALR, OPCODE_LOAD: a = model_regs[insn[19:15]];
            OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: a = '0;  // Neither rs field is read
            default: opcode = OPCODE_OPIMM;                // Runs as addi x0, x0, 0
        endcase
        return exec_result(opcode, iaddr, a, b);
    endfunction

    function automatic logic [`REG_ADDR_WIDTH-1:0] ref_rdest(input logic [`XLEN-1:0] insn);
        case (insn[6:0])
            OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC,
            OPCODE_JAL, OPCODE_JALR, OPCODE_LOAD: return insn[11:7];
            default: return '0;
        endcase
    endfunction

    // Unknown opcodes reach the execution unit as the plain noop word
    function automatic logic [`XLEN-1:0] issued_word(input logic [`XLEN-1:0] insn);
        case (insn[6:0])
            OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL,
            OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE: return insn;
            default: return NOP_INSN;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] make_insn(input logic [6:0] opcode,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [`XLEN-1:0] w;
        w        = $urandom();
        w[6:0]   = opcode;
        w[11:7]  = rd;
        w[19:15] = rs1;
        w[24:20] = rs2;
        return w;
    endfunction

    function automatic logic [6:0] random_opcode();
        int unsigned sel;
        sel = $urandom % 10;
        case (sel)
            0: return OPCODE_OP;
            1: return OPCODE_OPIMM;
            2: return OPCODE_LUI;
            3: return OPCODE_AUIPC;
            4: return OPCODE_JAL;
            5: return OPCODE_JALR;
            6: return OPCODE_BRANCH;
            7: return OPCODE_LOAD;
            8: return OPCODE_STORE;
            default: return OPCODE_UNKNOWN;
        endcase
    endfunction

    function automatic int unsigned total_errors();
        return mismatch_errors + other_errors + i_ooo_core_top.i_ooo_core_props.assert_fails;
    endfunction

    // ********************************************************
    // Stimulus tasks
    // ********************************************************
    task automatic push_insn(input logic [`XLEN-1:0] w);
        commit_t exp_e;
        while (insn_full) @(negedge clk);
        exp_e.valid = 1'b1;
        exp_e.iaddr = pc;
        exp_e.rdest = ref_rdest(w);
        exp_e.data  = ref_result(w, pc);
        if (exp_e.rdest != '0) model_regs[exp_e.rdest] = exp_e.data;
        exp_q.push_back(exp_e);
        issue_exp[push_count]  = issued_word(w);
        issue_wait[push_count] = 1'b1;
        insn_in.iaddr = pc;
        insn_in.insn  = w;
        insn_push     = 1'b1;
        pc            = pc + 4;
        push_count++;
        @(negedge clk);
        insn_push = 1'b0;
    endtask

    task automatic hold_cdb(input int cycles);
        cdb_hold <= 1'b1;
        repeat (cycles) @(negedge clk);
        cdb_hold <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_mismatch(input string field, input logic [`XLEN-1:0] exp_v,
            input logic [`XLEN-1:0] act_v);
        $display("Fail at %0t ns: %s expected %h, actual %h", $time, field, exp_v, act_v);
        mismatch_errors++;
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mismatch_errors, other_errors, i_ooo_core_top.i_ooo_core_props.assert_fails);
    endtask

    // ********************************************************
    // Execution-unit model and commit compare
    // ********************************************************
    always @(posedge clk) begin : issue_capture
        pending_t    p;
        int unsigned idx;
        cycle_count++;
        if (rst_n && issue_out.valid) begin
            p.tag  = issue_out.tag;
            p.data = exec_result(issue_out.opcode, issue_out.iaddr,
                                 issue_out.src_data[0], issue_out.src_data[1]);
            p.due  = cycle_count + 1 + ($urandom % 6);
            pend_q.push_back(p);
            if (cdb_hold && (issue_out.opcode inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL}))
                forced_issues++;
            idx = (issue_out.iaddr - BASE_PC) >> 2;
            if (idx >= NUM_INSNS || !issue_wait[idx]) begin
                $display("Issue of iaddr %h at %0t ns that was not waiting to issue",
                         issue_out.iaddr, $time);
                other_errors++;
            end else begin
                issue_wait[idx] = 1'b0;
                if (issue_out.insn !== issue_exp[idx])
                    report_mismatch("issue insn", issue_exp[idx], issue_out.insn);
                if (issue_out.opcode !== issue_exp[idx][6:0])
                    report_mismatch("issue opcode", issue_exp[idx][6:0], issue_out.opcode);
            end
        end
    end

    // The oldest due result goes first, so a short delay can overtake a long one
    always @(negedge clk) begin : cdb_driver
        int pick;
        pick = -1;
        if (!cdb_hold) begin
            for (int k = 0; k < pend_q.size(); k++) begin
                if (pick < 0 && pend_q[k].due <= cycle_count) pick = k;
            end
        end
        cdb_in = '0;
        if (pick >= 0) begin
            cdb_in.valid = 1'b1;
            cdb_in.tag   = pend_q[pick].tag;
            cdb_in.data  = pend_q[pick].data;
            pend_q.delete(pick);
        end
    end

    always @(posedge clk) begin : commit_compare
        commit_t exp_e;
        if (rst_n && cdb_hold && insn_full) full_seen = 1'b1;
        if (rst_n && commit_out.valid) begin
            commit_count++;
            if (cdb_hold) hold_commits++;
            if (exp_q.size() == 0) begin
                $display("Unexpected commit of iaddr %h at %0t ns with nothing outstanding",
                         commit_out.iaddr, $time);
                other_errors++;
            end else begin
                exp_e = exp_q.pop_front();
                if (commit_out.iaddr !== exp_e.iaddr)
                    report_mismatch("commit iaddr", exp_e.iaddr, commit_out.iaddr);
                if (commit_out.rdest !== exp_e.rdest)
                    report_mismatch("commit rdest", exp_e.rdest, commit_out.rdest);
                if (commit_out.data !== exp_e.data)
                    report_mismatch("commit data", exp_e.data, commit_out.data);
            end
        end
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles: commits did not drain, %0d of %0d committed",
                 cycle_count, commit_count, push_count);
        other_errors++;
        print_error_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin : main_sequence
        void'($urandom(32'hd2d9_04d7));
        rst_n      = 1'b0;
        insn_push  = 1'b0;
        insn_in    = '0;
        cdb_in     = '0;
        cdb_hold   = 1'b0;
        full_seen  = 1'b0;
        issue_wait = '0;
        pc         = BASE_PC;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Dense dependencies through x0..x7
        for (int i = 0; i < RAND_COUNT; i++) begin
            push_insn(make_insn(random_opcode(), 5'($urandom % 8), 5'($urandom % 8),
                                5'($urandom % 8)));
        end
        wait_drain();

        // LUI, AUIPC and JAL name x5 while it still has a producer in flight
        fork
            hold_cdb(30);
            begin : forced_pushes
                logic [6:0] fop;
                for (int k = 0; k < FORCED_COUNT / 3; k++) begin
                    fop = (k % 3 == 0) ? OPCODE_LUI : (k % 3 == 1) ? OPCODE_AUIPC : OPCODE_JAL;
                    push_insn(make_insn(OPCODE_OP, 5'd5, 5'd5, 5'd5));
                    push_insn(make_insn(fop, 5'd6, 5'd5, 5'd5));
                    push_insn(make_insn(OPCODE_OP, 5'd7, 5'd6, 5'd5));
                end
            end
        join
        wait_drain();
        if (forced_issues < 2) begin
            $display("Forced-ready operations did not issue while their rs registers were pending");
            other_errors++;
        end

        // Back-pressure on the CDB
        full_seen = 1'b0;
        fork
            hold_cdb(60);
            begin : bp_pushes
                for (int i = 0; i < BP_COUNT; i++) begin
                    push_insn(make_insn(random_opcode(), 5'($urandom % 8), 5'($urandom % 8),
                                        5'($urandom % 8)));
                end
            end
        join
        wait_drain();
        repeat (4) @(negedge clk);

        if (!full_seen) begin
            $display("insn_full never rose while the CDB was held back");
            other_errors++;
        end
        if (hold_commits != 0) begin
            $display("%0d instructions committed while the CDB was held back", hold_commits);
            other_errors++;
        end
        if (commit_count != push_count) begin
            $display("Pushed %0d instructions but %0d committed", push_count, commit_count);
            other_errors++;
        end

        print_error_counts();
        if (total_errors() == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== testbench/ooo_core_props.sv ====
`timescale 1ns/1ps

module ooo_core_props (
    input logic clk,
    input logic rst_n,
    input logic insn_push,
    input logic insn_full,
    input logic rd_en,
    input logic issue_valid,
    input logic commit_valid
);
    int unsigned assert_fails = 0;  // Read by the testbench for its closing error count

    // The first reset edge clears the state, so the check starts one edge later
    reset_quiet: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (!commit_valid && !issue_valid))
    else begin
        assert_fails++;
        $error("issue or commit valid while reset is held");
    end

    first_cycle_idle: assert property (@(posedge clk) $rose(rst_n) |=> !issue_valid)
    else begin
        assert_fails++;
        $error("issue valid in the cycle after reset release");
    end

    // A pop without a push can only lower the FIFO count
    no_full_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en && !insn_push) |=> !$rose(insn_full))
    else begin
        assert_fails++;
        $error("insn_full rose on a pop without a push");
    end

endmodule

bind ooo_core_top ooo_core_props i_ooo_core_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .insn_push    (insn_push),
    .insn_full    (insn_full),
    .rd_en        (rd_en),
    .issue_valid  (issue_out.valid),
    .commit_valid (commit_out.valid)
);

// ==== source/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 insn_push,
    input  ooo_pkg::insn_entry_t insn_in,
    input  ooo_pkg::cdb_t        cdb_in,
    output logic                 insn_full,
    output ooo_pkg::issue_t      issue_out,
    output ooo_pkg::commit_t     commit_out
);
    import ooo_pkg::*;

    insn_entry_t head;
    logic        empty;
    logic        rd_en;
    logic        alloc_en;
    rob_alloc_t  alloc;
    rob_lookup_t lookup;
    logic        rob_full;
    logic        rs_wr_en;
    rs_entry_t   rs_wr;
    logic        rs_full;

    insn_fifo i_insn_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (insn_push),
        .din   (insn_in),
        .full  (insn_full),
        .rd_en (rd_en),
        .head  (head),
        .empty (empty)
    );

    dispatch i_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (head),
        .empty    (empty),
        .rd_en    (rd_en),
        .alloc_en (alloc_en),
        .alloc    (alloc),
        .lookup   (lookup),
        .rob_full (rob_full),
        .rs_wr_en (rs_wr_en),
        .rs_wr    (rs_wr),
        .rs_full  (rs_full)
    );

    rob i_rob (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (alloc_en),
        .alloc      (alloc),
        .lookup     (lookup),
        .rob_full   (rob_full),
        .cdb_in     (cdb_in),
        .commit_out (commit_out)
    );

    // The CDB feeds both ROB completion and operand wakeup
    rsv_station i_rsv_station (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (rs_wr_en),
        .wr        (rs_wr),
        .rs_full   (rs_full),
        .cdb_in    (cdb_in),
        .issue_out (issue_out)
    );

endmodule

// ==== source/rsv_station.sv ====
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rsv_station (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  ooo_pkg::rs_entry_t wr,
    output logic               rs_full,
    input  ooo_pkg::cdb_t      cdb_in,
    output ooo_pkg::issue_t    issue_out
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    rs_entry_t            slots [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] slot_valid;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     iss_idx;
    logic                 iss_found;
    logic                 do_write;
    rs_entry_t            wr_cap;

    assign rs_full  = &slot_valid;
    assign do_write = wr_en & ~rs_full;

    // Scanning downwards leaves the lowest matching index selected
    always_comb begin
        free_idx  = '0;
        iss_idx   = '0;
        iss_found = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) free_idx = IDX_W'(i);
            if (slot_valid[i] && (&slots[i].src_rdy)) begin
                iss_idx   = IDX_W'(i);
                iss_found = 1'b1;
            end
        end
    end

    // Completion arriving on the same edge as dispatch
    always_comb begin
        wr_cap = wr;
        for (int j = 0; j < 2; j++) begin
            if (cdb_in.valid && !wr.src_rdy[j] && (wr.src_tag[j] == cdb_in.tag)) begin
                wr_cap.src_rdy[j]  = 1'b1;
                wr_cap.src_data[j] = cdb_in.data;
            end
        end
    end

    always_comb begin
        issue_out.valid    = iss_found;
        issue_out.tag      = slots[iss_idx].tag;
        issue_out.opcode   = slots[iss_idx].opcode;
        issue_out.insn     = slots[iss_idx].insn;
        issue_out.iaddr    = slots[iss_idx].iaddr;
        issue_out.src_data = slots[iss_idx].src_data;
    end

    // ********************************************************
    // Slot allocation and wakeup
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            if (iss_found) slot_valid[iss_idx] <= 1'b0;  // Issued slot frees right away
            if (do_write) slot_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int j = 0; j < 2; j++) begin
                if (cdb_in.valid && !slots[i].src_rdy[j] && (slots[i].src_tag[j] == cdb_in.tag)) begin
                    slots[i].src_rdy[j]  <= 1'b1;
                    slots[i].src_data[j] <= cdb_in.data;
                end
            end
        end
        if (do_write) slots[free_idx] <= wr_cap;
    end

endmodule

// ==== source/rob.sv ====
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rob (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc_en,
    input  ooo_pkg::rob_alloc_t  alloc,
    output ooo_pkg::rob_lookup_t lookup,
    output logic                 rob_full,
    input  ooo_pkg::cdb_t        cdb_in,
    output ooo_pkg::commit_t     commit_out
);
    import ooo_pkg::*;

    localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;

    typedef struct packed {
        rob_op_e                    op;
        logic [`REG_ADDR_WIDTH-1:0] rdest;
        logic [`XLEN-1:0]           iaddr;
        logic [`XLEN-1:0]           data;
    } rob_entry_t;

    rob_entry_t            entries [`ROB_DEPTH];
    rob_entry_t            head_ent;
    logic [`ROB_DEPTH-1:0] ent_valid;
    logic [`ROB_DEPTH-1:0] ent_done;
    logic [`TAG_WIDTH-1:0] head_ptr;
    logic [`TAG_WIDTH-1:0] tail_ptr;
    logic [`XLEN-1:0]      regfile [NUM_REGS];
    logic [NUM_REGS-1:0]   map_valid;  // Register has an in-flight producer
    logic [`TAG_WIDTH-1:0] map_tag [NUM_REGS];
    logic                  alloc_ok;
    logic                  commit_en;
    logic                  writes_reg;

    assign rob_full   = ent_valid[tail_ptr];   // Tail wrapped onto a live entry
    assign alloc_ok   = alloc_en & ~rob_full;
    assign head_ent   = entries[head_ptr];
    assign commit_en  = ent_valid[head_ptr] & ent_done[head_ptr];
    assign writes_reg = (head_ent.op != ROB_OP_STR) && (head_ent.rdest != '0);

    // ********************************************************
    // Source lookup through the rename table
    // ********************************************************
    always_comb begin
        lookup     = '0;
        lookup.tag = tail_ptr;
        for (int i = 0; i < 2; i++) begin
            lookup.src_tag[i] = map_tag[alloc.rsrc[i]];
            if (alloc.rsrc[i] == '0) begin
                lookup.src_rdy[i] = 1'b1;
            end else if (!map_valid[alloc.rsrc[i]]) begin
                lookup.src_rdy[i]  = 1'b1;
                lookup.src_data[i] = regfile[alloc.rsrc[i]];
            end else if (ent_done[map_tag[alloc.rsrc[i]]]) begin
                lookup.src_rdy[i]  = 1'b1;  // Finished but not yet retired
                lookup.src_data[i] = entries[map_tag[alloc.rsrc[i]]].data;
            end
        end
    end

    always_comb begin
        commit_out.valid = commit_en;
        commit_out.iaddr = head_ent.iaddr;
        commit_out.rdest = head_ent.rdest;
        commit_out.data  = head_ent.data;
    end

    // ********************************************************
    // Allocate, complete and retire
    // ********************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head_ptr  <= '0;
            tail_ptr  <= '0;
            map_valid <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                regfile[r] <= '0;
            end
        end else begin
            if (cdb_in.valid) ent_done[cdb_in.tag] <= 1'b1;
            if (commit_en) begin
                ent_valid[head_ptr] <= 1'b0;
                ent_done[head_ptr]  <= 1'b0;
                head_ptr            <= head_ptr + 1'b1;
                if (writes_reg) begin
                    regfile[head_ent.rdest] <= head_ent.data;
                    // A younger rename of the same register keeps its mapping
                    if (map_tag[head_ent.rdest] == head_ptr) map_valid[head_ent.rdest] <= 1'b0;
                end
            end
            if (alloc_ok) begin
                ent_valid[tail_ptr] <= 1'b1;
                ent_done[tail_ptr]  <= 1'b0;
                tail_ptr            <= tail_ptr + 1'b1;
                if (alloc.rdest != '0) map_valid[alloc.rdest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_in.valid) entries[cdb_in.tag].data <= cdb_in.data;
        if (alloc_ok) begin
            entries[tail_ptr].op    <= alloc.op;
            entries[tail_ptr].rdest <= alloc.rdest;
            entries[tail_ptr].iaddr <= alloc.iaddr;
            if (alloc.rdest != '0) map_tag[alloc.rdest] <= tail_ptr;
        end
    end

endmodule

// ==== source/dispatch.sv ====
`timescale 1ns/1ps
`include "ooo_defines.svh"

module dispatch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::insn_entry_t head,
    input  logic                 empty,
    output logic                 rd_en,
    output logic                 alloc_en,
    output ooo_pkg::rob_alloc_t  alloc,
    input  ooo_pkg::rob_lookup_t lookup,
    input  logic                 rob_full,
    output logic                 rs_wr_en,
    output ooo_pkg::rs_entry_t   rs_wr,
    input  logic                 rs_full
);
    import ooo_pkg::*;

    logic [6:0]                 opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rdest;
    rob_op_e                    op;
    logic                       use_rs1;
    logic                       use_rs2;
    logic                       noop;
    logic                       enable;

    assign opcode = head.insn[6:0];
    assign rd     = head.insn[11:7];
    assign rs1    = head.insn[19:15];
    assign rs2    = head.insn[24:20];

    // One enable moves the head into both the ROB and the station
    assign enable   = ~empty & ~rob_full & ~rs_full;
    assign rd_en    = enable;
    assign alloc_en = enable;
    assign rs_wr_en = enable;

    // ********************************************************
    // Opcode decode
    // ********************************************************
    always_comb begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        noop    = 1'b0;
        op      = ROB_OP_INT;
        rdest   = rd;
        case (opcode)
            OPCODE_OP: begin
                op = ROB_OP_INT;
            end
            OPCODE_OPIMM: begin
                use_rs2 = 1'b0;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
            end
            OPCODE_JAL: begin
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
                op      = ROB_OP_BR;
            end
            OPCODE_JALR: begin
                use_rs2 = 1'b0;
                op      = ROB_OP_BR;
            end
            OPCODE_BRANCH: begin
                op    = ROB_OP_BR;
                rdest = '0;
            end
            OPCODE_LOAD: begin
                use_rs2 = 1'b0;
                op      = ROB_OP_LD;
            end
            OPCODE_STORE: begin
                op    = ROB_OP_STR;
                rdest = '0;
            end
            default: begin
                // Unknown opcodes run as a plain addi with nothing written back
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
                noop    = 1'b1;
                rdest   = '0;
            end
        endcase
    end

    // Unread sources look up x0 and so come back ready with zero
    always_comb begin
        alloc.op      = op;
        alloc.rdest   = rdest;
        alloc.rsrc[0] = use_rs1 ? rs1 : '0;
        alloc.rsrc[1] = use_rs2 ? rs2 : '0;
        alloc.iaddr   = head.iaddr;

        rs_wr.opcode   = noop ? OPCODE_OPIMM : opcode;
        rs_wr.insn     = noop ? NOP_INSN : head.insn;
        rs_wr.iaddr    = head.iaddr;
        rs_wr.tag      = lookup.tag;
        rs_wr.src_tag  = lookup.src_tag;
        rs_wr.src_rdy  = lookup.src_rdy;
        rs_wr.src_data = lookup.src_data;
    end

endmodule

// ==== source/insn_fifo.sv ====
`timescale 1ns/1ps
`include "ooo_defines.svh"

module insn_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  ooo_pkg::insn_entry_t din,
    output logic                 full,
    input  logic                 rd_en,
    output ooo_pkg::insn_entry_t head,
    output logic                 empty
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    insn_entry_t      mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;   // A push into a full FIFO is dropped
    assign do_pop  = rd_en & ~empty;
    assign head    = mem[rd_ptr];    // Fall-through, head valid whenever not empty

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule

// ==== source/ooo_pkg.sv ====
`include "ooo_defines.svh"

package ooo_pkg;

    // RV32I major opcodes
    localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

    localparam logic [`XLEN-1:0] NOP_INSN = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [1:0] {
        ROB_OP_INT,
        ROB_OP_BR,
        ROB_OP_LD,
        ROB_OP_STR
    } rob_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] iaddr;
        logic [`XLEN-1:0] insn;
    } insn_entry_t;

    typedef struct packed {
        rob_op_e                         op;
        logic [`REG_ADDR_WIDTH-1:0]      rdest;
        logic [1:0][`REG_ADDR_WIDTH-1:0] rsrc;
        logic [`XLEN-1:0]                iaddr;
    } rob_alloc_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]      tag;
        logic [1:0][`TAG_WIDTH-1:0] src_tag;
        logic [1:0]                 src_rdy;
        logic [1:0][`XLEN-1:0]      src_data;
    } rob_lookup_t;

    typedef struct packed {
        logic [6:0]                 opcode;
        logic [`XLEN-1:0]           insn;
        logic [`XLEN-1:0]           iaddr;
        logic [`TAG_WIDTH-1:0]      tag;
        logic [1:0][`TAG_WIDTH-1:0] src_tag;
        logic [1:0]                 src_rdy;
        logic [1:0][`XLEN-1:0]      src_data;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`TAG_WIDTH-1:0] tag;
        logic [`XLEN-1:0]      data;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic [`TAG_WIDTH-1:0] tag;
        logic [6:0]            opcode;
        logic [`XLEN-1:0]      insn;
        logic [`XLEN-1:0]      iaddr;
        logic [1:0][`XLEN-1:0] src_data;
    } issue_t;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           iaddr;
        logic [`REG_ADDR_WIDTH-1:0] rdest;
        logic [`XLEN-1:0]           data;
    } commit_t;

endpackage

// ==== source/ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Datapath and register index widths
`define XLEN           32
`define REG_ADDR_WIDTH 5

// ROB depth and the tag that indexes it
`define ROB_DEPTH      8
`define TAG_WIDTH      3

// Reservation station slots
`define RS_DEPTH       4

// Instruction FIFO entries
`define FIFO_DEPTH     4

`endif
